//--- arp_defines.svh
`ifndef ARP_DEFINES_SVH
`define ARP_DEFINES_SVH

// number of board identities on the port
`define ARP_NUM_LANES 2

// lane i answers with base + i
`define ARP_BOARD_MAC_BASE 48'h02_12_34_56_78_00
`define ARP_BOARD_IP_BASE  32'hc0_a8_01_64

`endif

//--- eth_pkg.sv
`default_nettype none

package eth_pkg;

    typedef logic [47:0] mac_addr_t;   // station address
    typedef logic [31:0] ipv4_addr_t;  // ipv4 address, network order
    typedef logic [7:0]  gmii_byte_t;  // one gmii data beat
    typedef logic [31:0] crc32_t;      // fcs accumulator

endpackage

`default_nettype wire

//--- arp_pkg.sv
`default_nettype none

package arp_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_eth_head,
        st_arp_head,
        st_tx_data,
        st_tx_pad,
        st_crc
    } arp_tx_state_t;

    localparam int preamble_len = 8;   // 7x 55 then sfd
    localparam int eth_head_len = 14;
    localparam int arp_head_len = 8;
    localparam int arp_data_len = 20;  // sender then target pairs
    localparam int pad_len      = 18;  // up to 60 byte minimum
    localparam int fcs_len      = 4;

    localparam logic [15:0] eth_type_arp    = 16'h0806;
    localparam logic [15:0] hw_type_eth     = 16'h0001;
    localparam logic [15:0] proto_type_ipv4 = 16'h0800;
    localparam logic [15:0] op_reply        = 16'h0002;
    localparam logic [7:0]  hw_addr_len     = 8'h06;
    localparam logic [7:0]  proto_addr_len  = 8'h04;

endpackage

`default_nettype wire

//--- arp_lane_if.sv
`default_nettype none

interface arp_lane_if import eth_pkg::*; ();

    logic       refresh;      // start strobe for one reply
    mac_addr_t  dec_mac;      // requester mac
    ipv4_addr_t dec_ip;       // requester ip
    logic       arp_working;
    logic       gmii_tx_en;
    gmii_byte_t gmii_txd;

    modport lane (
        input  refresh, dec_mac, dec_ip,
        output arp_working, gmii_tx_en, gmii_txd
    );

    modport dispatch (
        output refresh, dec_mac, dec_ip,
        input  arp_working
    );

    modport mux (
        input gmii_tx_en, gmii_txd, arp_working
    );

endinterface

`default_nettype wire

//--- eth_crc32.sv
`default_nettype none

module eth_crc32 import eth_pkg::*; (
    input  wire             gmii_tx_clk,
    input  wire             rstn,
    input  wire             crc_en,
    input  wire             crc_clr,
    input  wire gmii_byte_t data,
    output crc32_t          crc_data,
    output crc32_t          crc_next
);

    localparam crc32_t crc_poly = 32'h04c1_1db7;

    // data enters lsb first, register kept in msb-first form
    always_comb begin
        crc_next = crc_data;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[31] ^ data[i]) begin
                crc_next = {crc_next[30:0], 1'b0} ^ crc_poly;
            end else begin
                crc_next = {crc_next[30:0], 1'b0};
            end
        end
    end

    always_ff @(posedge gmii_tx_clk or negedge rstn) begin
        if (!rstn) begin
            crc_data <= '1;
        end else if (crc_clr) begin
            crc_data <= '1;        // ready for next frame
        end else if (crc_en) begin
            crc_data <= crc_next;
        end
    end

endmodule

`default_nettype wire

//--- arp_frame_tx.sv
`default_nettype none

module arp_frame_tx import eth_pkg::*, arp_pkg::*; #(
    parameter mac_addr_t  board_mac = 48'h02_12_34_56_78_00,
    parameter ipv4_addr_t board_ip  = 32'hc0_a8_01_64
) (
    input  wire      gmii_tx_clk,
    input  wire      rstn,
    arp_lane_if.lane lane
);

    // fixed header bytes, first byte in the top bits
    localparam logic [111:0] eth_hdr = {48'hffff_ffff_ffff, board_mac, eth_type_arp};
    localparam logic [63:0]  arp_hdr = {hw_type_eth, proto_type_ipv4, hw_addr_len,
                                        proto_addr_len, op_reply};

    arp_tx_state_t st;
    arp_tx_state_t st_next;
    logic [4:0]    cnt;
    logic [4:0]    seg_last;
    mac_addr_t     peer_mac;
    ipv4_addr_t    peer_ip;
    logic [159:0]  arp_dat;
    gmii_byte_t    tx_byte;
    logic          fcs_last;
    logic          crc_en;
    logic          crc_clr;
    crc32_t        crc_data;
    crc32_t        crc_next;

    function automatic gmii_byte_t fcs_byte(input gmii_byte_t c);
        gmii_byte_t r;
        for (int i = 0; i < 8; i++) begin
            r[i] = ~c[7 - i];
        end
        return r;
    endfunction

    assign arp_dat = {board_mac, board_ip, peer_mac, peer_ip};

    always_comb begin
        seg_last = '0;
        st_next  = st_idle;
        case (st)
            st_preamble: begin
                seg_last = 5'(preamble_len - 1);
                st_next  = st_eth_head;
            end
            st_eth_head: begin
                seg_last = 5'(eth_head_len - 1);
                st_next  = st_arp_head;
            end
            st_arp_head: begin
                seg_last = 5'(arp_head_len - 1);
                st_next  = st_tx_data;
            end
            st_tx_data: begin
                seg_last = 5'(arp_data_len - 1);
                st_next  = st_tx_pad;
            end
            st_tx_pad: begin
                seg_last = 5'(pad_len - 1);
                st_next  = st_crc;
            end
            st_crc: begin
                seg_last = 5'(fcs_len - 1);
                st_next  = st_idle;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (st)
            st_preamble: tx_byte = (cnt == seg_last) ? 8'hd5 : 8'h55;
            st_eth_head: tx_byte = eth_hdr[8 * (eth_head_len - 1 - int'(cnt)) +: 8];
            st_arp_head: tx_byte = arp_hdr[8 * (arp_head_len - 1 - int'(cnt)) +: 8];
            st_tx_data:  tx_byte = arp_dat[8 * (arp_data_len - 1 - int'(cnt)) +: 8];
            st_crc: begin
                case (cnt[1:0])
                    2'd0:    tx_byte = fcs_byte(crc_next[31:24]);  // last pad byte still going in
                    2'd1:    tx_byte = fcs_byte(crc_data[23:16]);
                    2'd2:    tx_byte = fcs_byte(crc_data[15:8]);
                    default: tx_byte = fcs_byte(crc_data[7:0]);
                endcase
            end
            default:     tx_byte = 8'h00;  // pad and idle
        endcase
    end

    always_ff @(posedge gmii_tx_clk or negedge rstn) begin
        if (!rstn) begin
            st               <= st_idle;
            cnt              <= '0;
            lane.gmii_tx_en  <= 1'b0;
            lane.arp_working <= 1'b0;
            crc_en           <= 1'b0;
            fcs_last         <= 1'b0;
            crc_clr          <= 1'b0;
        end else begin
            if (st == st_idle) begin
                cnt <= '0;
                if (lane.refresh) begin
                    st <= st_preamble;
                end
            end else if (cnt == seg_last) begin
                st  <= st_next;
                cnt <= '0;
            end else begin
                cnt <= cnt + 5'd1;
            end
            // outputs trail the state by one cycle
            lane.gmii_tx_en  <= (st != st_idle);
            lane.arp_working <= (st != st_idle);
            crc_en   <= st inside {st_eth_head, st_arp_head, st_tx_data, st_tx_pad};
            fcs_last <= (st == st_crc) && (cnt == seg_last);
            crc_clr  <= fcs_last;
        end
    end

    always_ff @(posedge gmii_tx_clk) begin
        lane.gmii_txd <= tx_byte;
        if (lane.refresh && st == st_idle) begin
            peer_mac <= lane.dec_mac;
            peer_ip  <= lane.dec_ip;
        end
    end

    eth_crc32 u_crc (
        .gmii_tx_clk (gmii_tx_clk),
        .rstn        (rstn),
        .crc_en      (crc_en),
        .crc_clr     (crc_clr),
        .data        (lane.gmii_txd),
        .crc_data    (crc_data),
        .crc_next    (crc_next)
    );

endmodule

`default_nettype wire

//--- arp_req_dispatch.sv
`default_nettype none

`include "arp_defines.svh"

module arp_req_dispatch import eth_pkg::*; (
    input  wire             gmii_tx_clk,
    input  wire             rstn,
    input  wire             req,
    input  wire mac_addr_t  req_mac,
    input  wire ipv4_addr_t req_ip,
    input  wire ipv4_addr_t req_target_ip,
    input  wire             out_busy,
    arp_lane_if.dispatch    lanes [`ARP_NUM_LANES-1:0]
);

    localparam int num_lanes = `ARP_NUM_LANES;
    localparam int idx_w     = (num_lanes > 1) ? $clog2(num_lanes) : 1;

    logic [num_lanes-1:0] lane_busy;
    logic                 hit;
    logic [idx_w-1:0]     hit_idx;
    logic                 pend_vld;
    logic [idx_w-1:0]     pend_idx;
    mac_addr_t            pend_mac;
    ipv4_addr_t           pend_ip;
    logic                 fire;
    logic                 fire_d1;
    logic                 fire_d2;

    // lowest matching lane wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = num_lanes - 1; i >= 0; i--) begin
            if (req_target_ip == ipv4_addr_t'(`ARP_BOARD_IP_BASE + i)) begin
                hit     = 1'b1;
                hit_idx = idx_w'(i);
            end
        end
    end

    // guard covers the gap before the lane raises arp_working
    assign fire = pend_vld && !(|lane_busy) && !out_busy && !fire_d1 && !fire_d2;

    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        assign lane_busy[g]     = lanes[g].arp_working;
        assign lanes[g].refresh = fire && (pend_idx == idx_w'(g));
        assign lanes[g].dec_mac = pend_mac;
        assign lanes[g].dec_ip  = pend_ip;
    end

    always_ff @(posedge gmii_tx_clk or negedge rstn) begin
        if (!rstn) begin
            pend_vld <= 1'b0;
            pend_idx <= '0;
            fire_d1  <= 1'b0;
            fire_d2  <= 1'b0;
        end else begin
            fire_d1 <= fire;
            fire_d2 <= fire_d1;
            if (fire) begin
                pend_vld <= 1'b0;
            end else if (req && hit && !pend_vld) begin
                pend_vld <= 1'b1;
                pend_idx <= hit_idx;
            end
        end
    end

    always_ff @(posedge gmii_tx_clk) begin
        if (req && hit && !pend_vld) begin
            pend_mac <= req_mac;
            pend_ip  <= req_ip;
        end
    end

endmodule

`default_nettype wire

//--- gmii_tx_mux.sv
`default_nettype none

`include "arp_defines.svh"

module gmii_tx_mux import eth_pkg::*; (
    input  wire        gmii_tx_clk,
    input  wire        rstn,
    arp_lane_if.mux    lanes [`ARP_NUM_LANES-1:0],
    output logic       gmii_tx_en,
    output gmii_byte_t gmii_txd,
    output logic       tx_busy
);

    localparam int num_lanes = `ARP_NUM_LANES;

    logic [num_lanes-1:0] lane_work;
    logic [num_lanes-1:0] lane_en;
    gmii_byte_t           lane_txd [num_lanes];
    logic                 sel_en;
    gmii_byte_t           sel_txd;

    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        assign lane_work[g] = lanes[g].arp_working;
        assign lane_en[g]   = lanes[g].gmii_tx_en;
        assign lane_txd[g]  = lanes[g].gmii_txd;
    end

    // at most one lane works at a time
    always_comb begin
        sel_en  = 1'b0;
        sel_txd = 8'h00;
        for (int i = 0; i < num_lanes; i++) begin
            if (lane_work[i]) begin
                sel_en  = lane_en[i];
                sel_txd = lane_txd[i];
            end
        end
    end

    always_ff @(posedge gmii_tx_clk or negedge rstn) begin
        if (!rstn) begin
            gmii_tx_en <= 1'b0;
        end else begin
            gmii_tx_en <= sel_en;
        end
    end

    always_ff @(posedge gmii_tx_clk) begin
        gmii_txd <= sel_txd;
    end

    assign tx_busy = (|lane_work) || gmii_tx_en;  // includes the registered tail byte

endmodule

`default_nettype wire

//--- arp_reply_top.sv
`default_nettype none

`include "arp_defines.svh"

module arp_reply_top import eth_pkg::*; (
    input  wire             gmii_tx_clk,
    input  wire             rstn,
    input  wire             req,
    input  wire mac_addr_t  req_mac,
    input  wire ipv4_addr_t req_ip,
    input  wire ipv4_addr_t req_target_ip,
    output wire             gmii_tx_en,
    output wire gmii_byte_t gmii_txd,
    output wire             tx_busy
);

    arp_lane_if lane_if [`ARP_NUM_LANES-1:0] ();

    arp_req_dispatch u_dispatch (
        .gmii_tx_clk   (gmii_tx_clk),
        .rstn          (rstn),
        .req           (req),
        .req_mac       (req_mac),
        .req_ip        (req_ip),
        .req_target_ip (req_target_ip),
        .out_busy      (tx_busy),
        .lanes         (lane_if)
    );

    for (genvar g = 0; g < `ARP_NUM_LANES; g++) begin : g_lane
        arp_frame_tx #(
            .board_mac (mac_addr_t'(`ARP_BOARD_MAC_BASE + g)),
            .board_ip  (ipv4_addr_t'(`ARP_BOARD_IP_BASE + g))
        ) u_lane (
            .gmii_tx_clk (gmii_tx_clk),
            .rstn        (rstn),
            .lane        (lane_if[g])
        );
    end

    gmii_tx_mux u_mux (
        .gmii_tx_clk (gmii_tx_clk),
        .rstn        (rstn),
        .lanes       (lane_if),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd),
        .tx_busy     (tx_busy)
    );

endmodule

`default_nettype wire

//--- tb_arp_reply.sv
`default_nettype none

`include "arp_defines.svh"

module tb_arp_reply import eth_pkg::*, arp_pkg::*; ();

    localparam int frame_len = preamble_len + eth_head_len + arp_head_len + arp_data_len
                               + pad_len + fcs_len;
    localparam int eth_off   = preamble_len;
    localparam int arp_off   = eth_off + eth_head_len;
    localparam int dat_off   = arp_off + arp_head_len;
    localparam int pad_off   = dat_off + arp_data_len;
    localparam int fcs_off   = pad_off + pad_len;
    localparam int cyc_limit = 10 + 6 * 80 + 150;  // reset plus six requests and a margin

    logic       gmii_tx_clk;
    logic       rstn;
    logic       req;
    mac_addr_t  req_mac;
    ipv4_addr_t req_ip;
    ipv4_addr_t req_target_ip;
    wire        gmii_tx_en;
    gmii_byte_t gmii_txd;
    wire        tx_busy;

    logic       quiet_win;
    logic       prev_en = 1'b0;
    logic       req_idle = 1'b0;
    logic [15:0] lfsr = 16'd56;
    int         cyc = 0;
    int         last_req_cyc = 0;
    int         frames_done = 0;
    int         err_cnt = 0;
    gmii_byte_t cap_q [$];
    string      exp_name [$];
    int         exp_lane [$];
    mac_addr_t  exp_mac [$];
    ipv4_addr_t exp_ip [$];
    mac_addr_t  m;
    ipv4_addr_t p;

    arp_reply_top u_dut (
        .gmii_tx_clk   (gmii_tx_clk),
        .rstn          (rstn),
        .req           (req),
        .req_mac       (req_mac),
        .req_ip        (req_ip),
        .req_target_ip (req_target_ip),
        .gmii_tx_en    (gmii_tx_en),
        .gmii_txd      (gmii_txd),
        .tx_busy       (tx_busy)
    );

    initial begin
        gmii_tx_clk = 1'b0;
        forever #2 gmii_tx_clk = ~gmii_tx_clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [47:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[46:0], lfsr[15]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic random_peer(output mac_addr_t pm, output ipv4_addr_t pip);
        logic [47:0] b;
        take_bits(48, b);
        pm = b;
        take_bits(32, b);
        pip = b[31:0];
    endtask

    // reflected crc-32 with the fcs sent low byte first
    function automatic crc32_t frame_fcs(input gmii_byte_t f [frame_len]);
        crc32_t c;
        c = '1;
        for (int i = eth_off; i < fcs_off; i++) begin
            c = c ^ {24'h0, f[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    task automatic build_frame(input int ln, input mac_addr_t pm, input ipv4_addr_t pip,
                               output gmii_byte_t f [frame_len]);
        mac_addr_t    bm;
        ipv4_addr_t   bip;
        logic [79:0]  hdr;
        crc32_t       fcs;
        bm  = mac_addr_t'(`ARP_BOARD_MAC_BASE + ln);
        bip = ipv4_addr_t'(`ARP_BOARD_IP_BASE + ln);
        hdr = {eth_type_arp, hw_type_eth, proto_type_ipv4, hw_addr_len, proto_addr_len,
               op_reply};
        for (int i = 0; i < preamble_len; i++) begin
            f[i] = (i == preamble_len - 1) ? 8'hd5 : 8'h55;
        end
        for (int i = 0; i < 6; i++) begin
            f[eth_off + i]      = 8'hff;  // broadcast
            f[eth_off + 6 + i]  = bm[47 - 8 * i -: 8];
            f[dat_off + i]      = bm[47 - 8 * i -: 8];
            f[dat_off + 10 + i] = pm[47 - 8 * i -: 8];
        end
        for (int i = 0; i < 10; i++) begin
            f[eth_off + 12 + i] = hdr[79 - 8 * i -: 8];  // type then arp header
        end
        for (int i = 0; i < 4; i++) begin
            f[dat_off + 6 + i]  = bip[31 - 8 * i -: 8];
            f[dat_off + 16 + i] = pip[31 - 8 * i -: 8];
        end
        for (int i = pad_off; i < fcs_off; i++) begin
            f[i] = 8'h00;
        end
        fcs = frame_fcs(f);
        for (int i = 0; i < fcs_len; i++) begin
            f[fcs_off + i] = fcs[8 * i +: 8];
        end
    endtask

    task automatic expect_reply(input string name, input int ln, input mac_addr_t pm,
                                input ipv4_addr_t pip);
        exp_name.push_back(name);
        exp_lane.push_back(ln);
        exp_mac.push_back(pm);
        exp_ip.push_back(pip);
    endtask

    task automatic check_frame();
        gmii_byte_t f [frame_len];
        string      name;
        if (exp_name.size() == 0) begin
            err_cnt++;
            $display("a frame of %0d bytes came out with no reply expected", cap_q.size());
        end else begin
            name = exp_name.pop_front();
            build_frame(exp_lane.pop_front(), exp_mac.pop_front(), exp_ip.pop_front(), f);
            assert (cap_q.size() == frame_len) else begin
                err_cnt++;
                $display("[ERROR] %s length: expected %0d actual %0d", name, frame_len,
                         cap_q.size());
            end
            for (int i = 0; i < frame_len && i < cap_q.size(); i++) begin
                assert (cap_q[i] == f[i]) else begin
                    err_cnt++;
                    $display("[ERROR] %s byte %0d: expected %02h actual %02h", name, i, f[i],
                             cap_q[i]);
                end
            end
        end
    endtask

    task automatic send_req(input ipv4_addr_t tgt, input mac_addr_t pm, input ipv4_addr_t pip);
        @(posedge gmii_tx_clk);
        req           <= 1'b1;
        req_mac       <= pm;
        req_ip        <= pip;
        req_target_ip <= tgt;
        @(posedge gmii_tx_clk);
        req <= 1'b0;
    endtask

    always @(negedge gmii_tx_clk) begin
        cyc = cyc + 1;
        if (req) begin
            last_req_cyc = cyc;
            req_idle     = !tx_busy;  // only idle requests have a fixed latency
        end
        if (gmii_tx_en) begin
            if (!prev_en && req_idle) begin
                assert (cyc - last_req_cyc == 4) else begin
                    err_cnt++;
                    $display("[ERROR] start_latency: expected %0d actual %0d", 4,
                             cyc - last_req_cyc);
                end
            end
            cap_q.push_back(gmii_txd);
        end else if (prev_en) begin
            check_frame();
            cap_q.delete();
            frames_done++;
        end
        prev_en = gmii_tx_en;
    end

    assert property (@(negedge gmii_tx_clk) !rstn |-> (!gmii_tx_en && !tx_busy)) else begin
        err_cnt++;
        $display("outputs were not idle while reset was held");
    end

    assert property (@(posedge gmii_tx_clk) quiet_win |-> (!gmii_tx_en && !tx_busy)) else begin
        err_cnt++;
        $display("a request for an unknown target IP started traffic");
    end

    initial begin
        wait (cyc >= cyc_limit);
        $display("timeout: run did not finish within %0d cycles", cyc_limit);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rstn          = 1'b0;
        req           = 1'b0;
        req_mac       = '0;
        req_ip        = '0;
        req_target_ip = '0;
        quiet_win     = 1'b0;
        repeat (10) @(posedge gmii_tx_clk);
        rstn <= 1'b1;
        repeat (3) @(posedge gmii_tx_clk);

        random_peer(m, p);
        expect_reply("lane0_reply", 0, m, p);
        send_req(`ARP_BOARD_IP_BASE, m, p);
        wait (frames_done == 1);

        random_peer(m, p);
        expect_reply("lane1_reply", 1, m, p);
        send_req(`ARP_BOARD_IP_BASE + 1, m, p);
        wait (frames_done == 2);

        @(posedge gmii_tx_clk);
        quiet_win <= 1'b1;
        random_peer(m, p);
        send_req(`ARP_BOARD_IP_BASE + `ARP_NUM_LANES, m, p);  // one past the last lane
        repeat (30) @(posedge gmii_tx_clk);
        quiet_win <= 1'b0;

        random_peer(m, p);
        expect_reply("b2b_first", 0, m, p);
        send_req(`ARP_BOARD_IP_BASE, m, p);
        repeat (20) @(posedge gmii_tx_clk);
        random_peer(m, p);
        expect_reply("b2b_second", 1, m, p);
        send_req(`ARP_BOARD_IP_BASE + 1, m, p);
        repeat (4) @(posedge gmii_tx_clk);
        random_peer(m, p);
        send_req(`ARP_BOARD_IP_BASE, m, p);  // dropped while the slot is full
        wait (frames_done == 4);
        repeat (120) @(posedge gmii_tx_clk);

        assert (frames_done == 4 && exp_name.size() == 0) else begin
            err_cnt++;
            $display("saw %0d frames while %0d expected replies never came out", frames_done,
                     exp_name.size());
        end
        $display("frames: %0d  errors: %0d", frames_done, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
eth_pkg.sv
arp_pkg.sv
arp_lane_if.sv
eth_crc32.sv
arp_frame_tx.sv
arp_req_dispatch.sv
gmii_tx_mux.sv
arp_reply_top.sv
tb_arp_reply.sv
